/* verilog/axi_lite_pkg.sv */
/* AXI4-Lite bus definitions
   Channel bundles, bus widths and response codes */
package axi_lite_pkg;

	// Bus widths
	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 32;
	localparam int AXI_STRB_W = AXI_DATA_W / 8;

	typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
	typedef logic [AXI_DATA_W-1:0] axi_data_t;
	typedef logic [AXI_STRB_W-1:0] axi_strb_t;
	typedef logic [2:0]            axi_prot_t;
	typedef logic [1:0]            axi_resp_t;

	// Only OKAY is ever returned by the slave
	localparam axi_resp_t RESP_OKAY = 2'b00;

	// Master driven side of all five channels
	typedef struct packed {
		logic      awvalid;
		axi_addr_t awaddr;
		axi_prot_t awprot;
		logic      wvalid;
		axi_data_t wdata;
		axi_strb_t wstrb;
		logic      bready;
		logic      arvalid;
		axi_addr_t araddr;
		axi_prot_t arprot;
		logic      rready;
	} axi_lite_req_t;

	// Slave driven side
	typedef struct packed {
		logic      awready;
		logic      wready;
		logic      bvalid;
		axi_resp_t bresp;
		logic      arready;
		logic      rvalid;
		axi_data_t rdata;
		axi_resp_t rresp;
	} axi_lite_rsp_t;

endpackage

/* verilog/upsample_pkg.sv */
/* Up-sampling accelerator definitions
   Register map, sample-memory geometry, register bundles and engine states */
package upsample_pkg;

	// Register words
	localparam int CRF_DATA_W = 32;
	typedef logic [CRF_DATA_W-1:0] crf_word_t;

	// Register map, word indices
	localparam int NUM_REGS = 4;
	typedef logic [1:0] reg_idx_t;
	localparam reg_idx_t REG_UPSTR   = 2'd0;
	localparam reg_idx_t REG_UPENDR  = 2'd1;
	localparam reg_idx_t REG_UPSRCAR = 2'd2;
	localparam reg_idx_t REG_UPDSTAR = 2'd3;

	// UPSTR and UPENDR fields
	localparam int UPSTR_START_BIT = 0;
	localparam int UPSTR_CNT_LSB   = 8;
	localparam int UPENDR_DONE_BIT = 0;

	// Sample memory, mapped from word index RAM_WINDOW on
	localparam int RAM_AW     = 6;
	localparam int RAM_DEPTH  = 1 << RAM_AW;
	localparam int RAM_WINDOW = 64;
	typedef logic [RAM_AW-1:0] ram_addr_t;

	localparam int SAMPLE_W = 32;
	typedef logic [SAMPLE_W-1:0] sample_t;

	localparam int COUNT_W = 8;
	typedef logic [COUNT_W-1:0] count_t;

	typedef struct packed {
		crf_word_t upstr;
		crf_word_t upendr;
		crf_word_t upsrcar;
		crf_word_t updstar;
	} crf_regs_t;

	// PL side write request
	typedef struct packed {
		logic      wrt;
		reg_idx_t  waddr;
		crf_word_t wdata;
	} crf_pl_wr_t;

	typedef struct packed {
		logic      en;
		logic      we;
		ram_addr_t addr;
		sample_t   wdata;
	} ram_port_t;

	typedef enum logic [2:0] {
		IDLE,
		READ,
		WRITE0,
		WRITE1,
		CLR_START,
		SET_DONE
	} ups_state_t;

endpackage

/* verilog/sample_ram.sv */
`timescale 1ns/1ps
/* Sample memory
   64-word dual-port RAM, bus on port A and engine on port B */
module sample_ram (
	input  logic                    clk,
	input  upsample_pkg::ram_port_t port_a,
	input  upsample_pkg::ram_port_t port_b,
	output upsample_pkg::sample_t   rdata_a,
	output upsample_pkg::sample_t   rdata_b
);
	import upsample_pkg::*;

	sample_t mem [0:RAM_DEPTH-1];

	// Writes land on the edge
	always_ff @(posedge clk) begin
		if (port_a.en && port_a.we)
			mem[port_a.addr] <= port_a.wdata;
		if (port_b.en && port_b.we)
			mem[port_b.addr] <= port_b.wdata;
	end

	// Registered reads, held while the port writes or idles
	always_ff @(posedge clk) begin
		if (port_a.en && !port_a.we)
			rdata_a <= mem[port_a.addr];
	end

	always_ff @(posedge clk) begin
		if (port_b.en && !port_b.we)
			rdata_b <= mem[port_b.addr];
	end

	// Bus and engine never collide on one word
	a_no_dual_write: assert property (@(posedge clk)
		!(port_a.en && port_a.we && port_b.en && port_b.we && port_a.addr == port_b.addr));

endmodule

/* verilog/upsample_engine.sv */
`timescale 1ns/1ps
/* Up-sampling engine
   Reads each source sample, writes it twice to the destination, then flags completion */
module upsample_engine (
	input  logic                     clk,
	input  logic                     rst_n,
	input  upsample_pkg::crf_regs_t  regs,
	input  logic                     wbusy,
	output upsample_pkg::crf_pl_wr_t pl_wr,
	output upsample_pkg::ram_port_t  ram_b,
	input  upsample_pkg::sample_t    ram_b_rdata
);
	import upsample_pkg::*;

	ups_state_t state_q;
	ups_state_t state_d;
	count_t     cnt_q;
	ram_addr_t  src_q;
	ram_addr_t  dst_q;
	logic       start;
	count_t     job_cnt;
	logic       launch;

	assign start   = regs.upstr[UPSTR_START_BIT];
	assign job_cnt = regs.upstr[UPSTR_CNT_LSB +: COUNT_W];
	assign launch  = (state_q == IDLE) && start;

	always_comb begin
		state_d = state_q;
		case (state_q)
			// Zero count skips the memory phase
			IDLE:      if (start) state_d = (job_cnt == '0) ? CLR_START : READ;
			READ:      state_d = WRITE0;
			WRITE0:    state_d = WRITE1;
			WRITE1:    state_d = (cnt_q == count_t'(1)) ? CLR_START : READ;
			// Register writes retried while the bus holds wbusy
			CLR_START: if (!wbusy) state_d = SET_DONE;
			SET_DONE:  if (!wbusy) state_d = IDLE;
			default:   state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
			cnt_q   <= '0;
		end else begin
			state_q <= state_d;
			if (launch)
				cnt_q <= job_cnt;
			else if (state_q == WRITE1)
				cnt_q <= cnt_q - count_t'(1);
		end
	end

	// Word addresses wrap modulo 64 through their width
	always_ff @(posedge clk) begin
		if (launch) begin
			src_q <= regs.upsrcar[RAM_AW-1:0];
			dst_q <= regs.updstar[RAM_AW-1:0];
		end else if (state_q == WRITE1) begin
			src_q <= src_q + ram_addr_t'(1);
			dst_q <= dst_q + ram_addr_t'(2);
		end
	end

	// Port B read data stays valid through both writes
	always_comb begin
		ram_b.en    = 1'b0;
		ram_b.we    = 1'b0;
		ram_b.addr  = src_q;
		ram_b.wdata = ram_b_rdata;
		case (state_q)
			READ: begin
				ram_b.en = 1'b1;
			end
			WRITE0: begin
				ram_b.en   = 1'b1;
				ram_b.we   = 1'b1;
				ram_b.addr = dst_q;
			end
			WRITE1: begin
				ram_b.en   = 1'b1;
				ram_b.we   = 1'b1;
				ram_b.addr = dst_q + ram_addr_t'(1);
			end
			default: begin
			end
		endcase
	end

	// Clear start, then set done
	always_comb begin
		pl_wr.wrt   = (state_q == CLR_START) || (state_q == SET_DONE);
		pl_wr.waddr = (state_q == SET_DONE) ? REG_UPENDR : REG_UPSTR;
		pl_wr.wdata = '0;
		if (state_q == SET_DONE)
			pl_wr.wdata[UPENDR_DONE_BIT] = 1'b1;
	end

	// The read cycle has no write and its word is held through both writes
	a_no_write_in_read: assert property (@(posedge clk) disable iff (!rst_n)
		state_q == WRITE1 |-> !$past(ram_b.we, 2) && $stable(ram_b_rdata));

endmodule

/* verilog/config_register_file.sv */
`timescale 1ns/1ps
/* Configuration register file
   AXI4-Lite slave with four control registers, a PL write port and the memory window */
module config_register_file (
	input  logic                        clk,
	input  logic                        rst_n,
	input  axi_lite_pkg::axi_lite_req_t axi_req,
	output axi_lite_pkg::axi_lite_rsp_t axi_rsp,
	input  upsample_pkg::crf_pl_wr_t    pl_wr,
	output logic                        wbusy,
	output upsample_pkg::crf_regs_t     regs,
	output upsample_pkg::ram_port_t     ram_a,
	input  upsample_pkg::sample_t       ram_a_rdata,
	output logic                        irq
);
	import axi_lite_pkg::*;
	import upsample_pkg::*;

	// Byte address to word index decode
	function automatic logic is_reg(axi_addr_t addr);
		return (addr >> 2) < axi_addr_t'(NUM_REGS);
	endfunction

	function automatic logic is_ram(axi_addr_t addr);
		axi_addr_t widx;
		widx = addr >> 2;
		return (widx >= axi_addr_t'(RAM_WINDOW)) &&
			(widx < axi_addr_t'(RAM_WINDOW + RAM_DEPTH));
	endfunction

	function automatic reg_idx_t reg_index(axi_addr_t addr);
		return addr[3:2];
	endfunction

	function automatic ram_addr_t ram_index(axi_addr_t addr);
		return addr[2 +: RAM_AW];
	endfunction

	// One register word picked by index
	function automatic crf_word_t reg_word(crf_regs_t r, reg_idx_t idx);
		case (idx)
			REG_UPSTR:   return r.upstr;
			REG_UPENDR:  return r.upendr;
			REG_UPSRCAR: return r.upsrcar;
			default:     return r.updstar;
		endcase
	endfunction

	crf_regs_t regs_q;
	// Drives awready, wready and wbusy alike
	logic      aw_take_q;
	logic      bvalid_q;
	logic      arready_q;
	logic      rvalid_q;
	axi_data_t rdata_q;
	axi_data_t rd_mux;
	logic      axi_wren;
	logic      pl_take;
	logic      ram_wr;
	logic      axi_read;

	// Write handshake completes in the awready cycle
	assign axi_wren = axi_req.awvalid & axi_req.wvalid & aw_take_q;
	// PL write is refused only while an AXI write is being taken
	assign pl_take  = pl_wr.wrt & ~aw_take_q;
	assign ram_wr   = axi_wren & is_ram(axi_req.awaddr);
	assign axi_read = axi_req.arvalid & arready_q;

	// One write at a time with address and data accepted together
	// PL request in this cycle holds the AXI side off
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			aw_take_q <= 1'b0;
		end else if (pl_wr.wrt) begin
			aw_take_q <= 1'b0;
		end else begin
			aw_take_q <= axi_req.awvalid & axi_req.wvalid & ~bvalid_q & ~aw_take_q;
		end
	end

	// PL side updates registers first
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			regs_q <= '0;
		end else if (pl_take) begin
			case (pl_wr.waddr)
				REG_UPSTR:   regs_q.upstr   <= pl_wr.wdata;
				REG_UPENDR:  regs_q.upendr  <= pl_wr.wdata;
				REG_UPSRCAR: regs_q.upsrcar <= pl_wr.wdata;
				REG_UPDSTAR: regs_q.updstar <= pl_wr.wdata;
			endcase
		end else if (axi_wren && is_reg(axi_req.awaddr)) begin
			// Strobes ignored so the whole word is written
			case (reg_index(axi_req.awaddr))
				REG_UPSTR:   regs_q.upstr   <= axi_req.wdata;
				REG_UPENDR:  regs_q.upendr  <= axi_req.wdata;
				REG_UPSRCAR: regs_q.upsrcar <= axi_req.wdata;
				REG_UPDSTAR: regs_q.updstar <= axi_req.wdata;
			endcase
		end
	end

	// Response held until bready
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bvalid_q <= 1'b0;
		end else if (bvalid_q) begin
			if (axi_req.bready)
				bvalid_q <= 1'b0;
		end else begin
			bvalid_q <= axi_wren;
		end
	end

	// No new read while data is pending or the memory port is writing
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			arready_q <= 1'b0;
		end else begin
			arready_q <= axi_req.arvalid & ~arready_q & ~rvalid_q & ~ram_wr;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rvalid_q <= 1'b0;
		end else if (rvalid_q) begin
			if (axi_req.rready)
				rvalid_q <= 1'b0;
		end else begin
			rvalid_q <= axi_read;
		end
	end

	// Read data stays put until the next accepted read
	always_ff @(posedge clk) begin
		if (axi_read && !rvalid_q)
			rdata_q <= rd_mux;
	end

	// Memory data is already out in the arready cycle
	always_comb begin
		rd_mux = '0;
		if (is_ram(axi_req.araddr)) begin
			rd_mux = ram_a_rdata;
		end else if (is_reg(axi_req.araddr)) begin
			case (reg_index(axi_req.araddr))
				REG_UPSTR:   rd_mux = regs_q.upstr;
				REG_UPENDR:  rd_mux = regs_q.upendr;
				REG_UPSRCAR: rd_mux = regs_q.upsrcar;
				REG_UPDSTAR: rd_mux = regs_q.updstar;
			endcase
		end
	end

	// Port A writes win over reads taken straight from araddr
	always_comb begin
		ram_a.en    = ram_wr | (axi_req.arvalid & is_ram(axi_req.araddr));
		ram_a.we    = ram_wr;
		ram_a.addr  = ram_wr ? ram_index(axi_req.awaddr) : ram_index(axi_req.araddr);
		ram_a.wdata = axi_req.wdata;
	end

	assign axi_rsp = '{
		awready: aw_take_q,
		wready:  aw_take_q,
		bvalid:  bvalid_q,
		bresp:   RESP_OKAY,
		arready: arready_q,
		rvalid:  rvalid_q,
		rdata:   rdata_q,
		rresp:   RESP_OKAY
	};

	assign wbusy = aw_take_q;
	assign regs  = regs_q;
	// Done bit doubles as interrupt
	assign irq   = regs_q.upendr[UPENDR_DONE_BIT];

	// Every response is owed to a handshake one edge earlier
	a_bvalid_after_wr: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(bvalid_q) |-> $past(axi_wren));

	// A taken AXI register write is never lost to a PL write on the same edge
	a_single_writer: assert property (@(posedge clk) disable iff (!rst_n)
		axi_wren && is_reg(axi_req.awaddr) |=>
			reg_word(regs_q, $past(reg_index(axi_req.awaddr))) == $past(axi_req.wdata));

endmodule

/* verilog/upsample_top.sv */
`timescale 1ns/1ps
/* Up-sampling accelerator top
   Register file, engine and sample memory */
module upsample_top (
	input  logic                        clk,
	input  logic                        rst_n,
	input  axi_lite_pkg::axi_lite_req_t axi_req,
	output axi_lite_pkg::axi_lite_rsp_t axi_rsp,
	output logic                        irq
);
	import upsample_pkg::*;

	crf_regs_t  regs;
	crf_pl_wr_t pl_wr;
	logic       wbusy;
	ram_port_t  ram_a;
	ram_port_t  ram_b;
	sample_t    ram_a_rdata;
	sample_t    ram_b_rdata;

	// Bus side
	config_register_file i_crf (
		.clk         (clk),
		.rst_n       (rst_n),
		.axi_req     (axi_req),
		.axi_rsp     (axi_rsp),
		.pl_wr       (pl_wr),
		.wbusy       (wbusy),
		.regs        (regs),
		.ram_a       (ram_a),
		.ram_a_rdata (ram_a_rdata),
		.irq         (irq)
	);

	upsample_engine i_engine (
		.clk         (clk),
		.rst_n       (rst_n),
		.regs        (regs),
		.wbusy       (wbusy),
		.pl_wr       (pl_wr),
		.ram_b       (ram_b),
		.ram_b_rdata (ram_b_rdata)
	);

	// Port A to the bus, port B to the engine
	sample_ram i_ram (
		.clk     (clk),
		.port_a  (ram_a),
		.port_b  (ram_b),
		.rdata_a (ram_a_rdata),
		.rdata_b (ram_b_rdata)
	);

endmodule

/* include/axi_lite_tasks.svh */
/* AXI4-Lite master tasks for the testbench
   Single writes and reads on clk, axi_req and axi_rsp of the including module */
`ifndef AXI_LITE_TASKS_SVH
`define AXI_LITE_TASKS_SVH

// Cycle limit for every wait
localparam int AXI_TIMEOUT = 200;

// Drives on falling edges and holds bready low for hold cycles
task automatic axi_write(input axi_lite_pkg::axi_addr_t addr, input axi_lite_pkg::axi_data_t data,
		input int unsigned hold, output axi_lite_pkg::axi_resp_t resp, output bit ok);
	int n;
	ok = 1'b1;
	resp = '0;
	n = 0;
	@(negedge clk);
	axi_req.awvalid = 1'b1;
	axi_req.awaddr  = addr;
	axi_req.awprot  = '0;
	axi_req.wvalid  = 1'b1;
	axi_req.wdata   = data;
	axi_req.wstrb   = '1;
	axi_req.bready  = 1'b0;
	while (!axi_rsp.awready && n < AXI_TIMEOUT) begin
		@(negedge clk);
		n++;
	end
	// Address and data are taken in the same cycle
	ok = axi_rsp.awready && axi_rsp.wready;
	// Handshake taken on the edge in between
	@(negedge clk);
	axi_req.awvalid = 1'b0;
	axi_req.wvalid  = 1'b0;
	n = 0;
	while (!axi_rsp.bvalid && n < AXI_TIMEOUT) begin
		@(negedge clk);
		n++;
	end
	ok &= axi_rsp.bvalid;
	resp = axi_rsp.bresp;
	repeat (hold) begin
		@(negedge clk);
		ok &= axi_rsp.bvalid;
	end
	axi_req.bready = 1'b1;
	@(negedge clk);
	axi_req.bready = 1'b0;
endtask

// Checks rvalid and rdata stay stable while rready is held low
task automatic axi_read(input axi_lite_pkg::axi_addr_t addr, input int unsigned hold,
		output axi_lite_pkg::axi_data_t data, output axi_lite_pkg::axi_resp_t resp,
		output bit ok);
	int n;
	ok = 1'b1;
	data = '0;
	resp = '0;
	n = 0;
	@(negedge clk);
	axi_req.arvalid = 1'b1;
	axi_req.araddr  = addr;
	axi_req.arprot  = '0;
	axi_req.rready  = 1'b0;
	while (!axi_rsp.arready && n < AXI_TIMEOUT) begin
		@(negedge clk);
		n++;
	end
	ok = axi_rsp.arready;
	@(negedge clk);
	axi_req.arvalid = 1'b0;
	n = 0;
	while (!axi_rsp.rvalid && n < AXI_TIMEOUT) begin
		@(negedge clk);
		n++;
	end
	ok &= axi_rsp.rvalid;
	data = axi_rsp.rdata;
	resp = axi_rsp.rresp;
	repeat (hold) begin
		@(negedge clk);
		ok &= axi_rsp.rvalid && (axi_rsp.rdata == data);
	end
	axi_req.rready = 1'b1;
	@(negedge clk);
	axi_req.rready = 1'b0;
endtask

`endif

/* test/tb_upsample_top.sv */
`timescale 1ns/1ps
/* Testbench for the up-sampling accelerator
   Register, memory window, up-sampling jobs and back-pressure over AXI4-Lite */
module tb_upsample_top;
	import axi_lite_pkg::*;
	import upsample_pkg::*;

	logic          clk;
	logic          rst_n;
	axi_lite_req_t axi_req;
	axi_lite_rsp_t axi_rsp;
	logic          irq;

	// Known memory contents and the image expected after a job
	sample_t shadow  [RAM_DEPTH];
	sample_t exp_mem [RAM_DEPTH];

	// Compares waiting for the checker
	string     chk_name [$];
	crf_word_t chk_exp  [$];
	crf_word_t chk_act  [$];
	event      check_ev;

	int val_errors;
	int other_errors;
	int checks;
	int tests_run;
	int tests_failed;
	int errors_at_start;

	`include "axi_lite_tasks.svh"

	upsample_top i_dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.axi_req (axi_req),
		.axi_rsp (axi_rsp),
		.irq     (irq)
	);

	always #5 clk = ~clk;

	// Byte addresses of a register and of a memory word
	function automatic axi_addr_t reg_addr(reg_idx_t idx);
		return axi_addr_t'(idx) << 2;
	endfunction

	function automatic axi_addr_t mem_addr(ram_addr_t a);
		return (axi_addr_t'(RAM_WINDOW) + axi_addr_t'(a)) << 2;
	endfunction

	// Reference model writes each source word twice in a row
	// Samples handled in order with addresses wrapping at 64
	function automatic void upsample_ref(ram_addr_t src, ram_addr_t dst, int cnt);
		sample_t w;
		exp_mem = shadow;
		for (int i = 0; i < cnt; i++) begin
			w = exp_mem[src + ram_addr_t'(i)];
			exp_mem[dst + ram_addr_t'(2 * i)]     = w;
			exp_mem[dst + ram_addr_t'(2 * i + 1)] = w;
		end
	endfunction

	// Checker drains every queued compare
	always begin : compare
		string     name;
		crf_word_t exp_v;
		crf_word_t act_v;
		@(check_ev);
		while (chk_name.size() != 0) begin
			name  = chk_name.pop_front();
			exp_v = chk_exp.pop_front();
			act_v = chk_act.pop_front();
			checks++;
			assert (act_v === exp_v) else begin
				$display("FAIL %s expected 0x%08h actual 0x%08h", name, exp_v, act_v);
				val_errors++;
			end
		end
	end

	task automatic expect_value(input string name, input crf_word_t exp_v, input crf_word_t act_v);
		chk_name.push_back(name);
		chk_exp.push_back(exp_v);
		chk_act.push_back(act_v);
		-> check_ev;
	endtask

	task automatic report_error(input string msg);
		$display("ERROR %s", msg);
		other_errors++;
	endtask

	task automatic write_word(input axi_addr_t addr, input axi_data_t data,
			input int unsigned hold);
		axi_resp_t resp;
		bit        ok;
		axi_write(addr, data, hold, resp, ok);
		assert (ok) else
			report_error($sformatf("write to 0x%08h timed out, lacked wready or dropped bvalid",
				addr));
		expect_value("bresp", crf_word_t'(RESP_OKAY), crf_word_t'(resp));
	endtask

	// Read with rready held off for hold cycles
	task automatic read_expect(input axi_addr_t addr, input int unsigned hold,
			input string name, input crf_word_t exp_v);
		axi_data_t data;
		axi_resp_t resp;
		bit        ok;
		axi_read(addr, hold, data, resp, ok);
		assert (ok) else
			report_error($sformatf("read of 0x%08h timed out or rvalid/rdata moved", addr));
		expect_value("rresp", crf_word_t'(RESP_OKAY), crf_word_t'(resp));
		expect_value(name, exp_v, data);
	endtask

	task automatic write_sample(input ram_addr_t a, input sample_t v);
		write_word(mem_addr(a), v, 0);
		shadow[a] = v;
	endtask

	// Whole memory against the expected image
	task automatic check_mem();
		for (int i = 0; i < RAM_DEPTH; i++)
			read_expect(mem_addr(ram_addr_t'(i)), 0, $sformatf("rdata mem[%0d]", i),
				exp_mem[ram_addr_t'(i)]);
		shadow = exp_mem;
	endtask

	task automatic wait_irq(input int limit);
		int n;
		n = 0;
		while (!irq && n < limit) begin
			@(negedge clk);
			n++;
		end
		assert (irq) else report_error("irq did not rise before the timeout");
	endtask

	// One job from setup to cleared done bit
	task automatic run_job(input ram_addr_t src, input ram_addr_t dst, input int cnt,
			input bit contend);
		crf_word_t upstr;
		axi_data_t last_src;
		int        n;
		upstr = '0;
		upstr[UPSTR_START_BIT] = 1'b1;
		upstr[UPSTR_CNT_LSB +: COUNT_W] = count_t'(cnt);
		last_src = crf_word_t'(src);
		n = 0;
		write_word(reg_addr(REG_UPSRCAR), crf_word_t'(src), 0);
		write_word(reg_addr(REG_UPDSTAR), crf_word_t'(dst), 0);
		write_word(reg_addr(REG_UPSTR), upstr, 0);
		// Bus writes collide with the engine's PL writes
		while (contend && !irq && n < 100) begin
			last_src = $urandom;
			write_word(reg_addr(REG_UPSRCAR), last_src, 0);
			n++;
		end
		wait_irq(1000);
		upsample_ref(src, dst, cnt);
		check_mem();
		read_expect(reg_addr(REG_UPSTR), 0, "UPSTR", '0);
		read_expect(reg_addr(REG_UPENDR), 0, "UPENDR", 32'd1);
		read_expect(reg_addr(REG_UPSRCAR), 0, "UPSRCAR", last_src);
		// Clearing done drops irq
		write_word(reg_addr(REG_UPENDR), '0, 0);
		expect_value("irq", '0, crf_word_t'(irq));
	endtask

	task automatic finish_test(input string name);
		int n;
		n = 0;
		while (chk_name.size() != 0 && n < 10) begin
			@(posedge clk);
			n++;
		end
		assert (chk_name.size() == 0) else report_error("checker queue did not drain");
		tests_run++;
		if (val_errors + other_errors != errors_at_start) begin
			tests_failed++;
			$display("test %0d %s: failed", tests_run, name);
		end else begin
			$display("test %0d %s: ok", tests_run, name);
		end
		errors_at_start = val_errors + other_errors;
	endtask

	initial begin : stimulus
		axi_data_t   d;
		ram_addr_t   src;
		ram_addr_t   dst;
		ram_addr_t   a;
		int          cnt;
		int unsigned hold;
		clk = 1'b0;
		rst_n = 1'b0;
		axi_req = '0;
		val_errors = 0;
		other_errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		errors_at_start = 0;
		void'($urandom(27));
		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		// Reset values, read-back, unmapped indices
		for (int r = 0; r < NUM_REGS; r++)
			read_expect(reg_addr(reg_idx_t'(r)), 0, $sformatf("reg %0d", r), '0);
		expect_value("irq", '0, crf_word_t'(irq));
		d = $urandom;
		write_word(reg_addr(REG_UPSRCAR), d, 0);
		read_expect(reg_addr(REG_UPSRCAR), 0, "UPSRCAR", d);
		d = $urandom;
		write_word(reg_addr(REG_UPDSTAR), d, 0);
		read_expect(reg_addr(REG_UPDSTAR), 0, "UPDSTAR", d);
		write_word(axi_addr_t'(10 << 2), $urandom, 0);
		read_expect(axi_addr_t'(10 << 2), 0, "rdata index 10", '0);
		read_expect(axi_addr_t'(200 << 2), 0, "rdata index 200", '0);
		finish_test("registers");

		// Fill every word so the shadow is complete from here on
		for (int i = 0; i < RAM_DEPTH; i++)
			write_sample(ram_addr_t'(i), $urandom);
		exp_mem = shadow;
		check_mem();
		finish_test("memory window");

		src = ram_addr_t'(4);
		dst = ram_addr_t'(20);
		for (int i = 0; i < 8; i++)
			write_sample(src + ram_addr_t'(i), $urandom);
		run_job(src, dst, 8, 1'b0);
		finish_test("up-sampling job");

		for (int j = 0; j < 3; j++) begin
			src = ram_addr_t'($urandom % 64);
			dst = ram_addr_t'($urandom % 64);
			cnt = 1 + int'($urandom % 12);
			// First job runs past word 63
			if (j == 0) begin
				dst = ram_addr_t'(56 + $urandom % 8);
				cnt = 5 + int'($urandom % 8);
			end
			run_job(src, dst, cnt, 1'b0);
		end
		finish_test("wrapping jobs");

		run_job(ram_addr_t'($urandom % 64), ram_addr_t'($urandom % 64), 0, 1'b0);
		run_job(ram_addr_t'($urandom % 64), ram_addr_t'($urandom % 64), 10, 1'b1);
		finish_test("zero count and contention");

		// Random stalls on bready and rready
		for (int j = 0; j < 6; j++) begin
			a = ram_addr_t'($urandom % 64);
			d = $urandom;
			hold = 1 + $urandom % 8;
			write_word(mem_addr(a), d, hold);
			shadow[a] = d;
			hold = 1 + $urandom % 8;
			read_expect(mem_addr(a), hold, $sformatf("rdata mem[%0d]", a), d);
		end
		d = $urandom;
		hold = 1 + $urandom % 8;
		write_word(reg_addr(REG_UPDSTAR), d, hold);
		read_expect(reg_addr(REG_UPDSTAR), hold, "UPDSTAR", d);
		finish_test("back-pressure");

		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
			checks, val_errors + other_errors);
		if (val_errors + other_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* list.f */
+incdir+include
verilog/axi_lite_pkg.sv
verilog/upsample_pkg.sv
verilog/sample_ram.sv
verilog/upsample_engine.sv
verilog/config_register_file.sv
verilog/upsample_top.sv
test/tb_upsample_top.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for the pass line
cd "$(dirname "$0")" || exit 1
mkdir -p build

verilator --binary --timing --assert -f list.f --top-module tb_upsample_top \
	-Mdir build/obj -o sim_tb > build/build.log 2>&1 \
	|| { cat build/build.log; echo "build failed"; exit 1; }

./build/obj/sim_tb > build/sim.log 2>&1
cat build/sim.log

grep -qx "PASS: all tests" build/sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
